/* logic/wrpath_consts.svh */
// write path constants for PU count, bus widths, beat size and queue depths
`ifndef WRPATH_CONSTS_SVH
`define WRPATH_CONSTS_SVH

// processing units sharing the write path
`define WRP_NUM_PU 2

// PU index width, never below one bit
`define WRP_PU_ID_W ((`WRP_NUM_PU > 1) ? $clog2(`WRP_NUM_PU) : 1)

// byte address into memory
`define WRP_ADDR_W 32

// one beat of write data
`define WRP_DATA_W 64

// macro request length, counted in beats
`define WRP_LEN_W 10

// address step between consecutive beats
`define WRP_BEAT_BYTES 8

// pending macro requests held ahead of the sequencer
`define WRP_MACRO_Q_DEPTH 4

// beats waiting for a memory grant
`define WRP_REQ_Q_DEPTH 8

`endif

/* logic/wrpath_pkg.sv */
// write path types for addresses, beats, macro requests and memory requests
`include "wrpath_consts.svh"

package wrpath_pkg;

  typedef logic [`WRP_ADDR_W-1:0]  addr_t;   // byte address
  typedef logic [`WRP_DATA_W-1:0]  data_t;   // one 8-byte beat
  typedef logic [`WRP_LEN_W-1:0]   len_t;    // beats in a macro request
  typedef logic [`WRP_PU_ID_W-1:0] pu_id_t;  // owning PU

  // one bit per PU, used for buffer empty flags and pops
  typedef logic [`WRP_NUM_PU-1:0] pu_mask_t;

  // head word of every PU output buffer side by side, PU 0 in the low slot
  typedef data_t [`WRP_NUM_PU-1:0] outbuf_data_t;

  // macro write as posted by a PU
  typedef struct packed {
    addr_t  addr;    // start address, beat aligned
    len_t   len;     // zero is legal and issues no beats
    pu_id_t pu_id;   // whose output buffer feeds the beats
  } macro_req_t;

  // single beat toward the memory system
  typedef struct packed {
    addr_t addr;
    data_t data;
  } mem_req_t;

endpackage

/* logic/sync_fifo.sv */
// synchronous FIFO with a type-parameter payload and full/empty flags
`timescale 1ns/1ps

module sync_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  depth     = 4
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     push,
  input  payload_t din,
  input  logic     pop,
  output payload_t dout,
  output logic     full,
  output logic     empty
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);  // must hold 0..depth

  payload_t         mem [depth];  // storage
  logic [ptr_w-1:0] wr_ptr;       // next slot to write
  logic [ptr_w-1:0] rd_ptr;       // current head
  logic [cnt_w-1:0] count;        // occupancy
  logic             wr_en;
  logic             rd_en;

  // pointer step with wrap, so depth need not be a power of two
  function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
    if (p == ptr_w'(depth - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  assign wr_en = push && !full;    // keep state sane even on a bad push
  assign rd_en = pop && !empty;
  assign full  = (count == cnt_w'(depth));
  assign empty = (count == '0);
  assign dout  = mem[rd_ptr];      // head visible the cycle after its push

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (rd_en) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;  // push only
        2'b01:   count <= count - 1'b1;  // pop only
        default: count <= count;         // idle, or push and pop together
      endcase
    end
  end

  // producer must watch full since a push into a full queue is dropped
  a_no_overflow: assert property (@(posedge clk) disable iff (rst)
    !(push && full))
    else $error("sync_fifo push while full");

  // consumer side gates pop with a non-empty head
  a_no_underflow: assert property (@(posedge clk) disable iff (rst)
    !(pop && empty))
    else $error("sync_fifo pop while empty");

endmodule

/* logic/burst_sequencer.sv */
// burst sequencer that fractures macro writes into 8-byte beats from the PU buffers
`timescale 1ns/1ps
`include "wrpath_consts.svh"

module burst_sequencer import wrpath_pkg::*; (
  input  logic         clk,
  input  logic         rst,
  input  macro_req_t   macro_head,    // head of the macro queue
  input  logic         macro_empty,
  output logic         macro_pop,
  input  pu_mask_t     outbuf_empty,  // per PU, level
  input  outbuf_data_t outbuf_data,   // per PU head word
  output pu_mask_t     outbuf_pop,    // at most one-hot
  input  logic         req_full,      // request queue has no room
  output logic         beat_push,
  output mem_req_t     beat,
  output logic         busy,
  output logic         wr_done        // one cycle after the last beat
);

  logic   active;      // a macro request is being fractured
  addr_t  cur_addr;    // address of the next beat
  len_t   beats_left;  // beats still to issue
  pu_id_t cur_pu;      // owner of the active request
  logic   issue;       // one beat leaves this cycle
  logic   last;        // active request ends at this edge

  // load only when idle, so a new request waits one cycle after a done edge
  assign macro_pop = !active && !macro_empty;

  // a beat needs data from the owner and room downstream
  assign issue = active
              && (beats_left != '0)          // zero-length request issues nothing
              && !outbuf_empty[cur_pu]
              && !req_full;

  // count hits zero at this edge, or was zero from the start
  assign last = active
             && ((beats_left == '0) || (issue && (beats_left == len_t'(1))));

  assign busy      = active;
  assign beat_push = issue;

  // beat is formed every cycle, only taken on beat_push
  assign beat = '{addr: cur_addr, data: outbuf_data[cur_pu]};

  always_comb begin
    outbuf_pop = '0;
    if (issue) begin
      outbuf_pop[cur_pu] = 1'b1;  // consume the word going out with this beat
    end
  end

  // control state
  always_ff @(posedge clk) begin
    if (rst) begin
      active  <= 1'b0;
      wr_done <= 1'b0;
    end else begin
      wr_done <= last;           // pulse lands the cycle after going idle
      if (macro_pop) begin
        active <= 1'b1;
      end else if (last) begin
        active <= 1'b0;
      end
    end
  end

  // active request fields, only meaningful while active
  always_ff @(posedge clk) begin
    if (macro_pop) begin
      cur_addr   <= macro_head.addr;
      beats_left <= macro_head.len;
      cur_pu     <= macro_head.pu_id;
    end else if (issue) begin
      cur_addr   <= cur_addr + addr_t'(`WRP_BEAT_BYTES);  // next 8-byte beat
      beats_left <= beats_left - 1'b1;
    end
  end

  // one PU at a time
  a_pop_onehot: assert property (@(posedge clk) disable iff (rst)
    $onehot0(outbuf_pop))
    else $error("burst_sequencer pops more than one PU buffer");

  // the buffer flag seen by the PU must agree with the pop
  a_pop_not_empty: assert property (@(posedge clk) disable iff (rst)
    (outbuf_pop & outbuf_empty) == '0)
    else $error("burst_sequencer pops an empty PU buffer");

  // every popped word reaches the request queue
  a_pop_has_beat: assert property (@(posedge clk) disable iff (rst)
    (outbuf_pop != '0) |-> beat_push)
    else $error("burst_sequencer pops a word without pushing a beat");

endmodule

/* logic/wr_path_top.sv */
// write path top joining the macro queue, burst sequencer and memory request queue
`timescale 1ns/1ps
`include "wrpath_consts.svh"

module wr_path_top import wrpath_pkg::*; (
  input  logic         clk,
  input  logic         rst,
  input  logic         wr_req,        // strobe, one macro request per cycle
  input  macro_req_t   wr_macro,
  output logic         wr_ready,      // whole path idle
  output logic         wr_done,
  input  pu_mask_t     outbuf_empty,
  input  outbuf_data_t outbuf_data,
  output pu_mask_t     outbuf_pop,
  output logic         req_valid,
  input  logic         req_grant,
  output mem_req_t     mem_req
);

  // macro queue side
  macro_req_t macro_head;
  logic       macro_push;
  logic       macro_pop;
  logic       macro_full;
  logic       macro_empty;

  // request queue side
  mem_req_t   beat;
  logic       beat_push;
  logic       req_full;
  logic       req_empty;
  logic       req_pop;

  logic       busy;  // sequencer holds an active request

  assign macro_push = wr_req && !macro_full;  // a request while full is lost

  sync_fifo #(
    .payload_t (macro_req_t),
    .depth     (`WRP_MACRO_Q_DEPTH)
  ) macro_q (
    .clk   (clk),
    .rst   (rst),
    .push  (macro_push),
    .din   (wr_macro),
    .pop   (macro_pop),
    .dout  (macro_head),
    .full  (macro_full),
    .empty (macro_empty)
  );

  burst_sequencer seq (
    .clk          (clk),
    .rst          (rst),
    .macro_head   (macro_head),
    .macro_empty  (macro_empty),
    .macro_pop    (macro_pop),
    .outbuf_empty (outbuf_empty),
    .outbuf_data  (outbuf_data),
    .outbuf_pop   (outbuf_pop),
    .req_full     (req_full),
    .beat_push    (beat_push),
    .beat         (beat),
    .busy         (busy),
    .wr_done      (wr_done)
  );

  sync_fifo #(
    .payload_t (mem_req_t),
    .depth     (`WRP_REQ_Q_DEPTH)
  ) req_q (
    .clk   (clk),
    .rst   (rst),
    .push  (beat_push),
    .din   (beat),
    .pop   (req_pop),
    .dout  (mem_req),
    .full  (req_full),
    .empty (req_empty)
  );

  assign req_valid = !req_empty;              // head beat is always offered
  assign req_pop   = req_valid && req_grant;  // beat leaves on valid and grant

  // nothing queued, nothing in flight, every beat granted
  assign wr_ready = macro_empty && !busy && req_empty;

  // memory side sees a stable head until it grants
  a_hold_head: assert property (@(posedge clk) disable iff (rst)
    (req_valid && !req_grant) |=> (req_valid && $stable(mem_req)))
    else $error("wr_path_top head beat changed without a grant");

endmodule

/* tb/tb_model.svh */
// reference model for the write path, expands macro requests into expected beats and done pulses
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

data_t      model_words [`WRP_NUM_PU][$];  // words handed to each PU, not yet granted
macro_req_t pend_reqs [$];                 // accepted, done pulse still to come
int         head_issued;                   // pops seen for pend_reqs[0]
addr_t      exp_addr_q [$];                // beats expected on the memory port, in order
pu_id_t     exp_pu_q [$];                  // owner of each expected beat

// word given to a PU buffer, kept in buffer order
task automatic record_word(input int pu, input data_t w);
  model_words[pu].push_back(w);
endtask

// request enqueued at the coming edge, one beat per 8-byte step
task automatic expect_request(input macro_req_t r);
  pend_reqs.push_back(r);
  for (int i = 0; i < int'(r.len); i++) begin
    exp_addr_q.push_back(r.addr + addr_t'(i * `WRP_BEAT_BYTES));
    exp_pu_q.push_back(r.pu_id);  // data comes from this PU at grant time
  end
endtask

// word popped for the active request, which is always the oldest one
task automatic note_pop(input int pu);
  if (pend_reqs.size() == 0) begin
    report_fail("a PU buffer was popped with no request outstanding");
  end else begin
    check_eq("popped PU", pu, pend_reqs[0].pu_id);
    head_issued++;
    if (head_issued > int'(pend_reqs[0].len)) begin
      report_fail("more words were popped than the request length");
    end
  end
endtask

// done pulse closes the oldest request
task automatic retire_request();
  if (pend_reqs.size() == 0) begin
    report_fail("wr_done pulsed with no request outstanding");
  end else begin
    check_eq("beats issued before wr_done", head_issued, pend_reqs[0].len);
    void'(pend_reqs.pop_front());
    head_issued = 0;
  end
endtask

// beat leaving at the coming edge
task automatic check_beat(input mem_req_t b);
  pu_id_t pu;
  if (exp_addr_q.size() == 0) begin
    report_fail("a beat was granted while no beat was expected");
  end else begin
    pu = exp_pu_q.pop_front();
    check_eq("beat address", b.addr, exp_addr_q.pop_front());
    if (model_words[pu].size() == 0) begin
      report_fail("a beat was granted before its PU had any word");
    end else begin
      check_eq("beat data", b.data, model_words[pu].pop_front());
    end
  end
endtask

// nothing pending and every beat granted
function automatic bit all_retired();
  return (pend_reqs.size() == 0) && (exp_addr_q.size() == 0);
endfunction

`endif

/* tb/tb_wr_path.sv */
// testbench for the write path with random macro requests, PU buffers and memory grant
`timescale 1ns/1ps
`include "wrpath_consts.svh"

module tb_wr_path import wrpath_pkg::*; ();

  localparam int num_pu        = `WRP_NUM_PU;
  localparam int total_reqs    = 60;    // macro requests over the run
  localparam int ready_timeout = 4000;  // cycles allowed for one burst to drain
  localparam int buf_cap       = 6;     // emulated PU buffer depth

  logic         clk;
  logic         rst;
  logic         wr_req;
  macro_req_t   wr_macro;
  logic         wr_ready;
  logic         wr_done;
  pu_mask_t     outbuf_empty;
  outbuf_data_t outbuf_data;
  pu_mask_t     outbuf_pop;
  logic         req_valid;
  logic         req_grant;
  mem_req_t     mem_req;

  data_t buf_q [`WRP_NUM_PU][$];  // emulated PU output buffers, head at index 0
  logic  running;                 // background driver and monitor enabled
  int    seed_ret;
  int    reqs_sent;
  int    burst;

  `include "tb_model.svh"

  wr_path_top dut (
    .clk          (clk),
    .rst          (rst),
    .wr_req       (wr_req),
    .wr_macro     (wr_macro),
    .wr_ready     (wr_ready),
    .wr_done      (wr_done),
    .outbuf_empty (outbuf_empty),
    .outbuf_data  (outbuf_data),
    .outbuf_pop   (outbuf_pop),
    .req_valid    (req_valid),
    .req_grant    (req_grant),
    .mem_req      (mem_req)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period
  end

  // prints the reason, then ends the run
  task automatic report_fail(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "run aborted");
  endtask

  task automatic check_eq(input string what, input logic [127:0] got,
                          input logic [127:0] exp);
    if (got !== exp) begin
      report_fail($sformatf("error at %0t ns: %s is %0h, expected %0h",
                            $time, what, got, exp));
    end
  endtask

  // bounded wait, sampled at the falling edge where outputs are settled
  task automatic wait_ready(input int max_cycles);
    int n;
    n = 0;
    @(negedge clk);
    while (!wr_ready) begin
      n++;
      if (n > max_cycles) begin
        report_fail("timeout: wr_ready did not return high");
      end
      @(negedge clk);
    end
  endtask

  // back-to-back macro requests, one per cycle
  task automatic send_burst(input int count);
    macro_req_t r;
    for (int i = 0; i < count; i++) begin
      r.addr  = addr_t'($urandom) & ~addr_t'(`WRP_BEAT_BYTES - 1);  // beat aligned
      r.len   = len_t'($urandom % 13);                             // 0 to 12 beats
      r.pu_id = pu_id_t'($urandom % num_pu);
      @(posedge clk);
      #1;
      wr_req   = 1'b1;
      wr_macro = r;
    end
    @(posedge clk);
    #1;
    wr_req = 1'b0;
  endtask

  // refill buffers, show heads with random empty flags, randomize grant
  task automatic drive_buffers();
    data_t w;
    for (int p = 0; p < num_pu; p++) begin
      if (buf_q[p].size() < buf_cap && ($urandom % 2) == 0) begin
        w = {$urandom, $urandom};
        buf_q[p].push_back(w);
        record_word(p, w);
      end
      if (buf_q[p].size() > 0 && ($urandom % 4) != 0) begin
        outbuf_empty[p] = 1'b0;
        outbuf_data[p]  = buf_q[p][0];
      end else begin
        outbuf_empty[p] = 1'b1;  // word may exist but is hidden this cycle
        outbuf_data[p]  = '0;
      end
    end
    req_grant = ($urandom % 5) < 3;  // about 60 percent grant
  endtask

  // events seen here take effect at the next rising edge
  task automatic monitor_cycle();
    if (wr_done) begin
      retire_request();  // pulse reflects the previous edge, so close it first
    end
    check_eq("wr_ready", wr_ready, all_retired());
    check_eq("outbuf_pop one-hot", $onehot0(outbuf_pop), 1'b1);
    check_eq("outbuf_pop on an empty buffer", outbuf_pop & outbuf_empty, '0);
    for (int p = 0; p < num_pu; p++) begin
      if (outbuf_pop[p]) begin
        if (buf_q[p].size() == 0) begin
          report_fail("a PU buffer holding no word was popped");
        end else begin
          void'(buf_q[p].pop_front());
          note_pop(p);
        end
      end
    end
    if (req_valid && req_grant) begin
      check_beat(mem_req);
    end
    if (wr_req) begin
      expect_request(wr_macro);
    end
  endtask

  always @(posedge clk) begin
    if (running) begin
      #1;
      drive_buffers();
    end
  end

  always @(negedge clk) begin
    if (running) begin
      monitor_cycle();
    end
  end

  initial begin
    seed_ret     = $urandom(79468);
    running      = 1'b0;
    rst          = 1'b1;
    wr_req       = 1'b0;
    wr_macro     = '0;
    outbuf_empty = '1;
    outbuf_data  = '0;
    req_grant    = 1'b0;
    reqs_sent    = 0;
    burst        = 0;
    head_issued  = 0;

    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;

    // idle state right after reset
    @(negedge clk);
    check_eq("req_valid after reset", req_valid, 1'b0);
    check_eq("outbuf_pop after reset", outbuf_pop, '0);
    check_eq("wr_done after reset", wr_done, 1'b0);
    check_eq("wr_ready after reset", wr_ready, 1'b1);

    @(posedge clk);
    #1;
    running = 1'b1;

    while (reqs_sent < total_reqs) begin
      wait_ready(ready_timeout);
      burst = 1 + ($urandom % `WRP_MACRO_Q_DEPTH);
      send_burst(burst);
      reqs_sent += burst;
    end
    wait_ready(ready_timeout);

    @(posedge clk);  // monitor has handled the last falling edge
    #1;
    if (all_retired()) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      $display("requests or beats were still outstanding at the end of the run");
      $display("=== FAIL ===");
      $fatal(1, "run aborted");
    end
  end

endmodule

/* verilog.f */
+incdir+logic
+incdir+tb
logic/wrpath_pkg.sv
logic/sync_fifo.sv
logic/burst_sequencer.sv
logic/wr_path_top.sv
tb/tb_wr_path.sv

/* run_sim.sh */
#!/bin/sh
# build and run the write path testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal \
  --top-module tb_wr_path \
  -f verilog.f \
  --Mdir obj_dir -o tb_wr_path
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/tb_wr_path
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit 1
fi

echo "simulation finished"
exit 0
